// ==== hw/phy_pkg.sv ====
// shared types, out-of-band states and sata primitive constants
// default timing values for the phy fabric logic

package phy_pkg;

    // one 4-byte data word as seen on the transceiver parallel side
    typedef logic [31:0] word_t;

    // one flag per byte, used for control characters and commas
    typedef logic [3:0] kflags_t;

    // device side out-of-band sequence
    typedef enum logic [2:0] {
        st_idle,
        st_wait_comreset,
        st_send_cominit,
        st_wait_comwake,
        st_send_comwake,
        st_send_align,
        st_recal,
        st_link_up
    } oob_state_e;

    // K28.5 D10.2 D10.2 D27.3, K character in byte 0
    localparam word_t   ALIGN_PRIM = 32'h7B4A4ABC;
    localparam kflags_t ALIGN_K    = 4'b0001;

    // rx settle time: pma 17, cdr phase 1, cdr freq 1, dfe/lpm 15, eye scan 1
    localparam int unsigned RX_SETTLE_CYCLES_DEF = 17 + 1 + 1 + 15 + 1;

    // tx pma reset time
    localparam int unsigned TX_SETTLE_CYCLES_DEF = 1;

    // internal reset pulse after both plls lock
    localparam int unsigned RST_PULSE_CYCLES_DEF = 7;

    // partial tx reset issued after the oob exchange
    localparam int unsigned PCS_RESET_CYCLES_DEF = 8;

    // longest allowed stay in any oob wait state
    localparam int unsigned OOB_TIMEOUT_DEF = 64;

endpackage

// ==== hw/phy_reset_ctrl.sv ====
`timescale 1ns/1ns
// transceiver reset sequencing: settle timers, user-ready levels,
// internal reset pulse and the transmit pcs reset timer

module phy_reset_ctrl #(
    parameter int unsigned RX_SETTLE_CYCLES = phy_pkg::RX_SETTLE_CYCLES_DEF,
    parameter int unsigned TX_SETTLE_CYCLES = phy_pkg::TX_SETTLE_CYCLES_DEF,
    parameter int unsigned RST_PULSE_CYCLES = phy_pkg::RST_PULSE_CYCLES_DEF,
    parameter int unsigned PCS_RESET_CYCLES = phy_pkg::PCS_RESET_CYCLES_DEF
) (
    input  logic clk,
    input  logic extrst,
    input  logic cplllock,
    input  logic usrpll_locked,
    input  logic rxresetdone,
    input  logic txresetdone,
    input  logic txpcsreset_req,
    output logic rst,
    output logic rxuserrdy,
    output logic txuserrdy,
    output logic gtx_ready,
    output logic txpcsreset,
    output logic recal_tx_done
);

    localparam int unsigned RX_W  = $clog2(RX_SETTLE_CYCLES + 1);
    localparam int unsigned TX_W  = $clog2(TX_SETTLE_CYCLES + 1);
    localparam int unsigned RST_W = $clog2(RST_PULSE_CYCLES + 2);
    localparam int unsigned PCS_W = $clog2(PCS_RESET_CYCLES + 1);

    logic [RX_W-1:0]  rx_settle_cnt;
    logic [TX_W-1:0]  tx_settle_cnt;
    logic [RST_W-1:0] rst_timer;
    logic [PCS_W-1:0] pcs_cnt;
    logic             locks_ok;
    logic             rx_settled;
    logic             tx_settled;
    logic             pcs_stop;
    logic             rst_r;

    assign locks_ok   = cplllock & usrpll_locked;
    assign rx_settled = rx_settle_cnt == RX_W'(RX_SETTLE_CYCLES);
    assign tx_settled = tx_settle_cnt == TX_W'(TX_SETTLE_CYCLES);

    // settle timers restart whenever the channel pll loses lock
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            rx_settle_cnt <= '0;
            tx_settle_cnt <= '0;
        end else if (!cplllock) begin
            rx_settle_cnt <= '0;
            tx_settle_cnt <= '0;
        end else begin
            if (!rx_settled)
                rx_settle_cnt <= rx_settle_cnt + 1'b1;
            if (!tx_settled)
                tx_settle_cnt <= tx_settle_cnt + 1'b1;
        end
    end

    assign rxuserrdy = locks_ok & rx_settled;
    assign txuserrdy = locks_ok & tx_settled;
    assign gtx_ready = rxuserrdy & txuserrdy & rxresetdone & txresetdone;

    // timer values 1..RST_PULSE_CYCLES map to the pulse, then it parks
    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            rst_timer <= '0;
            rst_r     <= 1'b0;
        end else begin
            if (!locks_ok)
                rst_timer <= '0;
            else if (rst_timer != RST_W'(RST_PULSE_CYCLES + 1))
                rst_timer <= rst_timer + 1'b1;
            rst_r <= (rst_timer != '0) && (rst_timer <= RST_W'(RST_PULSE_CYCLES));
        end
    end

    assign rst = rst_r;

    // partial tx reset, runs from the first request cycle
    assign pcs_stop = pcs_cnt == PCS_W'(PCS_RESET_CYCLES);

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst)
            pcs_cnt <= '0;
        else if (rst_r || !txpcsreset_req)
            pcs_cnt <= '0;
        else if (!pcs_stop)
            pcs_cnt <= pcs_cnt + 1'b1;
    end

    assign txpcsreset    = txpcsreset_req & ~pcs_stop;
    assign recal_tx_done = pcs_stop & gtx_ready;

    a_pcs_reset_len: assert property (@(posedge clk) disable iff (extrst)
        $rose(txpcsreset) |-> ##PCS_RESET_CYCLES !txpcsreset)
        else $error("txpcsreset held past its length");

    a_rst_not_ready: assert property (@(posedge clk) disable iff (extrst)
        !(rst && gtx_ready))
        else $error("internal reset while transceiver ready");

endmodule

// ==== hw/oob_dev_fsm.sv ====
`timescale 1ns/1ns
// device side out-of-band state machine with wait timeout
// and transmit word selection

module oob_dev_fsm #(
    parameter int unsigned OOB_TIMEOUT = phy_pkg::OOB_TIMEOUT_DEF
) (
    input  logic             clk,
    input  logic             extrst,
    input  logic             rst,
    input  logic             gtx_ready,
    input  logic             rxcominitdet,
    input  logic             rxcomwakedet,
    input  logic             recal_tx_done,
    input  logic             rxelecidle,
    input  phy_pkg::word_t   rx_word,
    input  phy_pkg::kflags_t rx_kflags,
    input  phy_pkg::word_t   ll_data_in,
    input  phy_pkg::kflags_t ll_charisk_in,
    output logic             txcominit,
    output logic             txcomwake,
    output logic             txelecidle,
    output logic             txpcsreset_req,
    output logic             phy_ready,
    output phy_pkg::word_t   tx_data,
    output phy_pkg::kflags_t tx_charisk
);

    import phy_pkg::*;

    localparam int unsigned WAIT_W = $clog2(OOB_TIMEOUT + 1);

    oob_state_e        state;
    oob_state_e        state_next;
    logic [WAIT_W-1:0] wait_cnt;
    logic              waiting;
    logic              timeout;
    logic              align_det;

    // ALIGN only counts while the line carries data
    assign align_det = !rxelecidle && (rx_word == ALIGN_PRIM) && (rx_kflags == ALIGN_K);

    // states with a bounded wait
    assign waiting = state inside {st_wait_comwake, st_send_align, st_recal};
    assign timeout = waiting && (wait_cnt == WAIT_W'(OOB_TIMEOUT - 1));

    always_comb begin
        state_next = state;
        case (state)
            st_idle:
                if (gtx_ready)
                    state_next = st_wait_comreset;
            st_wait_comreset:
                if (rxcominitdet)
                    state_next = st_send_cominit;
            st_send_cominit:
                state_next = st_wait_comwake;
            st_wait_comwake:
                if (rxcomwakedet)
                    state_next = st_send_comwake;
            st_send_comwake:
                state_next = st_send_align;
            st_send_align:
                if (align_det)
                    state_next = st_recal;
            st_recal:
                if (recal_tx_done)
                    state_next = st_link_up;
            st_link_up:
                // host restarts the link with a new comreset
                if (rxcominitdet)
                    state_next = st_send_cominit;
            default:
                state_next = st_idle;
        endcase
        // a wait that ends in its last cycle still moves on
        if (timeout && state_next == state)
            state_next = st_idle;
        if (!gtx_ready)
            state_next = st_idle;
    end

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst) begin
            state    <= st_idle;
            wait_cnt <= '0;
        end else if (rst) begin
            state    <= st_idle;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            if (state_next != state)
                wait_cnt <= '0;
            else if (waiting)
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign txcominit      = state == st_send_cominit;
    assign txcomwake      = state == st_send_comwake;
    assign txpcsreset_req = state == st_recal;
    assign phy_ready      = state == st_link_up;

    // link layer data passes straight through once the link is up
    always_comb begin
        case (state)
            st_send_align, st_recal: begin
                tx_data    = ALIGN_PRIM;
                tx_charisk = ALIGN_K;
                txelecidle = 1'b0;
            end
            st_link_up: begin
                tx_data    = ll_data_in;
                tx_charisk = ll_charisk_in;
                txelecidle = 1'b0;
            end
            default: begin
                tx_data    = '0;
                tx_charisk = '0;
                txelecidle = 1'b1;
            end
        endcase
    end

    a_oob_exclusive: assert property (@(posedge clk) disable iff (extrst)
        !(txcominit && txcomwake))
        else $error("cominit and comwake requested together");

    a_ready_active: assert property (@(posedge clk) disable iff (extrst)
        phy_ready |-> !txelecidle)
        else $error("link up with transmitter idle");

endmodule

// ==== hw/rx_word_aligner.sv ====
`timescale 1ns/1ns
// receive word alignment to a 4-byte boundary by halfword exchange

module rx_word_aligner (
    input  logic             clk,
    input  logic             extrst,
    input  logic             rst,
    input  phy_pkg::word_t   rx_data,
    input  phy_pkg::kflags_t rx_charisk,
    input  phy_pkg::kflags_t rx_comma,
    output phy_pkg::word_t   al_data,
    output phy_pkg::kflags_t al_charisk
);

    import phy_pkg::*;

    logic    shift;
    logic    shift_next;
    word_t   data_swap;
    kflags_t k_swap;

    // comma at byte 2 means the word arrived two bytes off
    always_comb begin
        if (rx_comma[2])
            shift_next = 1'b1;
        else if (rx_comma[0])
            shift_next = 1'b0;
        else
            shift_next = shift;
    end

    assign data_swap = {rx_data[15:0], rx_data[31:16]};
    assign k_swap    = {rx_charisk[1:0], rx_charisk[3:2]};

    always_ff @(posedge clk or posedge extrst) begin
        if (extrst)
            shift <= 1'b0;
        else if (rst)
            shift <= 1'b0;
        else
            shift <= shift_next;
    end

    // uses the decision updated from this same word
    always_ff @(posedge clk) begin
        al_data    <= shift_next ? data_swap : rx_data;
        al_charisk <= shift_next ? k_swap : rx_charisk;
    end

    a_single_comma: assert property (@(posedge clk) disable iff (extrst)
        !(rx_comma[0] && rx_comma[2]))
        else $error("commas at bytes 0 and 2 in one word");

endmodule

// ==== hw/sata_phy_dev.sv ====
`timescale 1ns/1ns
// device side sata phy fabric logic: reset sequencing, oob exchange
// and receive alignment around an external transceiver

module sata_phy_dev #(
    parameter int unsigned RX_SETTLE_CYCLES = phy_pkg::RX_SETTLE_CYCLES_DEF,
    parameter int unsigned TX_SETTLE_CYCLES = phy_pkg::TX_SETTLE_CYCLES_DEF,
    parameter int unsigned RST_PULSE_CYCLES = phy_pkg::RST_PULSE_CYCLES_DEF,
    parameter int unsigned PCS_RESET_CYCLES = phy_pkg::PCS_RESET_CYCLES_DEF,
    parameter int unsigned OOB_TIMEOUT      = phy_pkg::OOB_TIMEOUT_DEF
) (
    input  logic             clk,
    input  logic             extrst,
    output logic             rst,
    // transceiver status
    input  logic             cplllock,
    input  logic             usrpll_locked,
    input  logic             rxresetdone,
    input  logic             txresetdone,
    input  logic             rxcominitdet,
    input  logic             rxcomwakedet,
    input  logic             rxelecidle,
    // transceiver receive side
    input  phy_pkg::word_t   rx_data,
    input  phy_pkg::kflags_t rx_charisk,
    input  phy_pkg::kflags_t rx_comma,
    // transceiver control
    output logic             rxuserrdy,
    output logic             txuserrdy,
    output logic             txcominit,
    output logic             txcomwake,
    output logic             txelecidle,
    output logic             txpcsreset,
    output phy_pkg::word_t   tx_data,
    output phy_pkg::kflags_t tx_charisk,
    // link layer
    input  phy_pkg::word_t   ll_data_in,
    input  phy_pkg::kflags_t ll_charisk_in,
    output phy_pkg::word_t   ll_data_out,
    output phy_pkg::kflags_t ll_charisk_out,
    output logic             phy_ready
);

    logic gtx_ready;
    logic recal_tx_done;
    logic txpcsreset_req;

    phy_reset_ctrl #(
        .RX_SETTLE_CYCLES (RX_SETTLE_CYCLES),
        .TX_SETTLE_CYCLES (TX_SETTLE_CYCLES),
        .RST_PULSE_CYCLES (RST_PULSE_CYCLES),
        .PCS_RESET_CYCLES (PCS_RESET_CYCLES)
    ) u_reset_ctrl (
        .clk            (clk),
        .extrst         (extrst),
        .cplllock       (cplllock),
        .usrpll_locked  (usrpll_locked),
        .rxresetdone    (rxresetdone),
        .txresetdone    (txresetdone),
        .txpcsreset_req (txpcsreset_req),
        .rst            (rst),
        .rxuserrdy      (rxuserrdy),
        .txuserrdy      (txuserrdy),
        .gtx_ready      (gtx_ready),
        .txpcsreset     (txpcsreset),
        .recal_tx_done  (recal_tx_done)
    );

    // the fsm watches the aligned word for ALIGN
    oob_dev_fsm #(
        .OOB_TIMEOUT (OOB_TIMEOUT)
    ) u_oob (
        .clk            (clk),
        .extrst         (extrst),
        .rst            (rst),
        .gtx_ready      (gtx_ready),
        .rxcominitdet   (rxcominitdet),
        .rxcomwakedet   (rxcomwakedet),
        .recal_tx_done  (recal_tx_done),
        .rxelecidle     (rxelecidle),
        .rx_word        (ll_data_out),
        .rx_kflags      (ll_charisk_out),
        .ll_data_in     (ll_data_in),
        .ll_charisk_in  (ll_charisk_in),
        .txcominit      (txcominit),
        .txcomwake      (txcomwake),
        .txelecidle     (txelecidle),
        .txpcsreset_req (txpcsreset_req),
        .phy_ready      (phy_ready),
        .tx_data        (tx_data),
        .tx_charisk     (tx_charisk)
    );

    rx_word_aligner u_aligner (
        .clk        (clk),
        .extrst     (extrst),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_charisk (rx_charisk),
        .rx_comma   (rx_comma),
        .al_data    (ll_data_out),
        .al_charisk (ll_charisk_out)
    );

endmodule

// ==== tests/tb_checks.svh ====
// typed compare tasks for the sata phy testbench
// the first mismatch ends the run

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_word(input phy_pkg::word_t got, input phy_pkg::word_t exp,
                          input string what);
    if (got !== exp)
        stop_with_failure($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                                    $time, what, got, exp));
endtask

task automatic check_kflags(input phy_pkg::kflags_t got, input phy_pkg::kflags_t exp,
                            input string what);
    if (got !== exp)
        stop_with_failure($sformatf("FAIL at %0t ns: %s is %b, expected %b",
                                    $time, what, got, exp));
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
        stop_with_failure($sformatf("FAIL at %0t ns: %s is %b, expected %b",
                                    $time, what, got, exp));
endtask

`endif

// ==== tests/tb_sata_phy_dev.sv ====
`timescale 1ns/1ns
// testbench for sata_phy_dev: clock, reset, transceiver model,
// host stimulus table and watchdog

module tb_sata_phy_dev;

    import phy_pkg::*;

    localparam int unsigned RX_SETTLE = 35;
    localparam int unsigned TX_SETTLE = 1;
    localparam int unsigned RST_PULSE = 7;
    localparam int unsigned PCS_RESET = 8;
    localparam int unsigned OOB_LIMIT = 64;
    localparam logic [1:0] S_NONE  = 2'd0;
    localparam logic [1:0] S_CINIT = 2'd1;
    localparam logic [1:0] S_CWAKE = 2'd2;

    // one host stimulus row, held for a number of cycles
    typedef struct packed {
        logic [7:0] cycles;
        logic [1:0] strobe;
        logic       idle;
        word_t      data;
        kflags_t    k;
        kflags_t    comma;
        logic       check;
        word_t      exp_data;
        kflags_t    exp_k;
    } row_t;

    logic    clk;
    logic    extrst;
    logic    cplllock, usrpll_locked, rxresetdone, txresetdone;
    logic    rxcominitdet, rxcomwakedet, rxelecidle;
    word_t   rx_data, ll_data_in, tx_data, ll_data_out;
    kflags_t rx_charisk, rx_comma, ll_charisk_in, tx_charisk, ll_charisk_out;
    logic    rst, rxuserrdy, txuserrdy, txcominit, txcomwake;
    logic    txelecidle, txpcsreset, phy_ready;

    row_t    rows[$];
    int      table_cycles = 0;
    logic    rows_ready = 1'b0;
    integer  seed;
    logic    exp_pending = 1'b0;
    word_t   exp_data;
    kflags_t exp_k;
    int      cycle = 0;
    int      lock_cycle = 0;
    int      since_cinit = 1000;
    int      rst_len = 0;
    int      rst_pulses = 0;
    int      pcs_len = 0;
    int      pcs_runs = 0;
    int      cominit_pulses = 0;
    int      comwake_pulses = 0;
    int      ready_rises = 0;
    logic    rst_prev = 1'b0;
    logic    cominit_prev = 1'b0;
    logic    comwake_prev = 1'b0;
    logic    ready_prev = 1'b0;
    logic    rxrdy_seen = 1'b0;

    `include "tb_checks.svh"

    sata_phy_dev #(
        .RX_SETTLE_CYCLES (RX_SETTLE),
        .TX_SETTLE_CYCLES (TX_SETTLE),
        .RST_PULSE_CYCLES (RST_PULSE),
        .PCS_RESET_CYCLES (PCS_RESET),
        .OOB_TIMEOUT      (OOB_LIMIT)
    ) DUT (.*);

    always #50 clk = ~clk;

    task automatic add_row(input logic [7:0] n, input logic [1:0] strobe, input logic idle,
                           input word_t data, input kflags_t k, input kflags_t comma,
                           input logic check, input word_t exp_d, input kflags_t exp_kf);
        row_t r;
        r = {n, strobe, idle, data, k, comma, check, exp_d, exp_kf};
        rows.push_back(r);
        table_cycles += n;
    endtask

    task automatic build_table();
        add_row(3, S_NONE, 1, '0, '0, '0, 1, '0, '0);
        add_row(1, S_CINIT, 1, '0, '0, '0, 1, '0, '0);
        // no comwake, so the wait runs out
        add_row(72, S_NONE, 1, '0, '0, '0, 1, '0, '0);
        // late comwake must go unanswered
        add_row(1, S_CWAKE, 1, '0, '0, '0, 1, '0, '0);
        add_row(4, S_NONE, 1, '0, '0, '0, 1, '0, '0);
        add_row(1, S_CINIT, 1, '0, '0, '0, 1, '0, '0);
        add_row(4, S_NONE, 1, '0, '0, '0, 1, '0, '0);
        add_row(1, S_CWAKE, 1, '0, '0, '0, 1, '0, '0);
        add_row(3, S_NONE, 0, 32'h4A4A4A4A, 4'h0, 4'h0, 1, 32'h4A4A4A4A, 4'h0);
        // ALIGN two bytes off, comma at byte 2
        add_row(1, S_NONE, 0, 32'h4ABC7B4A, 4'b0100, 4'b0100, 1, ALIGN_PRIM, ALIGN_K);
        add_row(2, S_NONE, 0, 32'h11223344, 4'b0010, 4'h0, 1, 32'h33441122, 4'b1000);
        // comma back at byte 0
        add_row(1, S_NONE, 0, ALIGN_PRIM, ALIGN_K, 4'b0001, 1, ALIGN_PRIM, ALIGN_K);
        add_row(2, S_NONE, 0, 32'h11223344, 4'b0010, 4'h0, 1, 32'h11223344, 4'b0010);
        add_row(14, S_NONE, 0, 32'h4A4A4A4A, 4'h0, 4'h0, 1, 32'h4A4A4A4A, 4'h0);
        // host restarts a live link
        add_row(1, S_CINIT, 0, 32'h4A4A4A4A, 4'h0, 4'h0, 1, 32'h4A4A4A4A, 4'h0);
        add_row(4, S_NONE, 0, 32'h4A4A4A4A, 4'h0, 4'h0, 1, 32'h4A4A4A4A, 4'h0);
    endtask

    // sample at the falling edge, then drive the next cycle
    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        cycle++;
        since_cinit++;
        if (exp_pending) begin
            check_word(ll_data_out, exp_data, "ll_data_out");
            check_kflags(ll_charisk_out, exp_k, "ll_charisk_out");
        end
        if (rst)
            rst_len++;
        else if (rst_prev) begin
            check_word(word_t'(rst_len), word_t'(RST_PULSE), "rst pulse length");
            rst_pulses++;
            rst_len = 0;
        end
        if (rxuserrdy && !rxrdy_seen) begin
            rxrdy_seen = 1'b1;
            check_bit(cycle - lock_cycle >= RX_SETTLE, 1'b1, "rxuserrdy after settle time");
        end
        check_bit(txcominit && cominit_prev, 1'b0, "txcominit longer than one cycle");
        check_bit(txcomwake && comwake_prev, 1'b0, "txcomwake longer than one cycle");
        if (txcominit && !cominit_prev) begin
            cominit_pulses++;
            check_bit(since_cinit <= OOB_LIMIT, 1'b1, "txcominit after a comreset");
        end
        if (txcomwake && !comwake_prev)
            comwake_pulses++;
        if (txpcsreset) begin
            pcs_len++;
            check_bit(txelecidle, 1'b0, "txelecidle during recalibration");
        end else if (pcs_len != 0) begin
            check_word(word_t'(pcs_len), word_t'(PCS_RESET), "txpcsreset length");
            pcs_runs++;
            pcs_len = 0;
        end
        if (phy_ready && !ready_prev)
            ready_rises++;
        if (!phy_ready && ready_prev)
            check_bit(txelecidle, 1'b1, "txelecidle after link drop");
        // transmit word follows the visible state
        if (phy_ready) begin
            check_bit(txelecidle, 1'b0, "txelecidle in link up");
            check_word(tx_data, ll_data_in, "tx_data in link up");
            check_kflags(tx_charisk, ll_charisk_in, "tx_charisk in link up");
        end else if (!txelecidle) begin
            check_word(tx_data, ALIGN_PRIM, "tx_data while aligning");
            check_kflags(tx_charisk, ALIGN_K, "tx_charisk while aligning");
        end else begin
            check_word(tx_data, '0, "tx_data while idle");
            check_kflags(tx_charisk, '0, "tx_charisk while idle");
        end
        rst_prev = rst;
        cominit_prev = txcominit;
        comwake_prev = txcomwake;
        ready_prev = phy_ready;
        // transceiver model
        if (rxuserrdy)
            rxresetdone = 1'b1;
        if (txuserrdy)
            txresetdone = 1'b1;
        rxcominitdet = 1'b0;
        rxcomwakedet = 1'b0;
        exp_pending = 1'b0;
        rnd = $random(seed);
        ll_data_in = rnd;
        rnd = $random(seed);
        ll_charisk_in = rnd[3:0];
    endtask

    initial begin
        wait (rows_ready);
        #((table_cycles + 400) * 100);
        stop_with_failure("watchdog expired before the test sequence finished");
    end

    initial begin
        clk = 1'b0;
        extrst = 1'b1;
        {cplllock, usrpll_locked, rxresetdone, txresetdone} = '0;
        {rxcominitdet, rxcomwakedet} = '0;
        rxelecidle = 1'b1;
        rx_data = '0;
        rx_charisk = '0;
        rx_comma = '0;
        ll_data_in = '0;
        ll_charisk_in = '0;
        seed = 84601;
        build_table();
        rows_ready = 1'b1;
        repeat (8) next_cycle();
        check_bit(phy_ready, 1'b0, "phy_ready in reset");
        check_bit(txcominit, 1'b0, "txcominit in reset");
        check_bit(txcomwake, 1'b0, "txcomwake in reset");
        check_bit(txpcsreset, 1'b0, "txpcsreset in reset");
        check_bit(rxuserrdy, 1'b0, "rxuserrdy in reset");
        check_bit(txuserrdy, 1'b0, "txuserrdy in reset");
        check_bit(txelecidle, 1'b1, "txelecidle in reset");
        extrst = 1'b0;
        next_cycle();
        cplllock = 1'b1;
        usrpll_locked = 1'b1;
        lock_cycle = cycle;
        while (!(rxresetdone && txresetdone))
            next_cycle();
        repeat (2) next_cycle();
        foreach (rows[i]) begin
            row_t r;
            r = rows[i];
            for (int n = 0; n < r.cycles; n++) begin
                next_cycle();
                rxcominitdet = (n == 0) && (r.strobe == S_CINIT);
                rxcomwakedet = (n == 0) && (r.strobe == S_CWAKE);
                if (rxcominitdet)
                    since_cinit = 0;
                rxelecidle = r.idle;
                rx_data = r.data;
                rx_charisk = r.k;
                rx_comma = r.comma;
                exp_pending = r.check;
                exp_data = r.exp_data;
                exp_k = r.exp_k;
            end
        end
        next_cycle();
        check_word(word_t'(rst_pulses), 32'd1, "number of rst pulses");
        check_word(word_t'(cominit_pulses), 32'd3, "number of txcominit pulses");
        check_word(word_t'(comwake_pulses), 32'd1, "number of txcomwake pulses");
        check_word(word_t'(pcs_runs), 32'd1, "number of txpcsreset runs");
        check_word(word_t'(ready_rises), 32'd1, "number of link ups");
        check_bit(phy_ready, 1'b0, "phy_ready after restart");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== sata_phy_dev.f ====
+incdir+tests
hw/phy_pkg.sv
hw/phy_reset_ctrl.sv
hw/oob_dev_fsm.sv
hw/rx_word_aligner.sv
hw/sata_phy_dev.sv
tests/tb_sata_phy_dev.sv

// ==== Bender.yml ====
package:
  name: sata_phy_dev

sources:
  - hw/phy_pkg.sv
  - hw/phy_reset_ctrl.sv
  - hw/oob_dev_fsm.sv
  - hw/rx_word_aligner.sv
  - hw/sata_phy_dev.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_sata_phy_dev.sv
